/* hw/aluOpsPkg.sv */
// ALU operation package: operation codes, sizes, CCR flag layout and decoded operation
`default_nettype none

package aluOpsPkg;

	localparam int dataW = 16;     // Operand and result width
	localparam int ccrW  = 5;      // X N Z V C

	// Flag positions inside the CCR
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	// CCR write masks, one bit per flag
	localparam logic [ccrW-1:0] maskAll  = 5'b11111;   // XNZVC
	localparam logic [ccrW-1:0] maskNzvc = 5'b01111;   // X kept
	localparam logic [ccrW-1:0] maskNone = 5'b00000;   // Nothing written

	// Kept operations
	typedef enum logic [4:0] {
		opAdd,
		opAddx,
		opSub,
		opSubx,
		opCmp,
		opAnd,
		opOr,
		opEor,
		opNeg,
		opNegx,
		opNot,
		opClr,
		opAbcd,
		opSbcd,
		opAsl,
		opAsr,
		opLsl,
		opLsr,
		opRol,
		opRor,
		opRoxl,
		opRoxr,
		opIllegal
	} aluOpE;

	typedef enum logic {
		sizeByte = 1'b0,
		sizeWord = 1'b1
	} opSizeE;

	// Operation after decode, travels with the data to the CCR stage
	typedef struct packed {
		aluOpE            op;
		opSizeE           size;
		logic [ccrW-1:0]  ccrMask;     // Flags this operation writes
		logic             stickyZ;     // Z may clear but never set
	} decodedOpS;

endpackage

`default_nettype wire

/* hw/aluBusPkg.sv */
// ALU bus package: request, response and decode-to-execute payloads
`default_nettype none

package aluBusPkg;

	import aluOpsPkg::*;

	// Request into the core
	typedef struct packed {
		logic [15:0]       opcode;   // 68K opcode word
		logic [dataW-1:0]  src;
		logic [dataW-1:0]  dst;
	} aluReqS;

	// Response out of the core
	typedef struct packed {
		logic [dataW-1:0]  result;
		logic [ccrW-1:0]   ccr;      // CCR after this operation
		logic              illegal;  // Opcode not supported
	} aluRespS;

	// Decode register contents
	typedef struct packed {
		decodedOpS         dec;
		logic [dataW-1:0]  src;
		logic [dataW-1:0]  dst;
	} execS;

endpackage

`default_nettype wire

/* hw/bcdCorrect.sv */
// BCD adjust: turns a binary byte sum or difference into packed decimal with carry and V
`timescale 1ns/100ps
`default_nettype none

module bcdCorrect
	import aluOpsPkg::*;
(
	input  logic [7:0]  binResult,
	input  logic        isAdd,
	input  logic        carryIn,     // Binary byte carry or borrow
	input  logic        halfCarry,   // Carry or borrow out of the low nibble
	output logic [7:0]  bcdResult,
	output logic        decCarry,
	output logic        overflow
);

	logic [8:0] lowStep;    // After low nibble adjust
	logic [4:0] highStep;   // High nibble plus carry
	logic       lowAdj;
	logic       highAdj;

	// Nibble above 9
	function automatic logic gt9(input logic [3:0] nib);
		return nib[3] & (nib[2] | nib[1]);
	endfunction

	assign lowAdj = halfCarry | (isAdd & gt9(binResult[3:0]));

	always_comb begin
		if (isAdd) begin
			lowStep  = {1'b0, binResult} + (lowAdj ? 9'd6 : 9'd0);
			highAdj  = carryIn | gt9(lowStep[7:4]) | lowStep[8];
			highStep = lowStep[8:4] + (highAdj ? 5'd6 : 5'd0);
			overflow = highStep[3] & ~binResult[7];
		end else begin
			lowStep  = {1'b0, binResult} - (lowAdj ? 9'd6 : 9'd0);
			highAdj  = carryIn;   // Subtract only corrects on borrow
			highStep = lowStep[8:4] - (highAdj ? 5'd6 : 5'd0);
			overflow = ~highStep[3] & binResult[7];
		end
	end

	assign bcdResult = {highStep[3:0], lowStep[3:0]};
	assign decCarry  = highStep[4] | carryIn;

endmodule

`default_nettype wire

/* hw/opDecoder.sv */
// Opcode decoder: maps a 68K opcode word to an ALU operation, size and CCR mask, registered
`timescale 1ns/100ps
`default_nettype none

module opDecoder
	import aluOpsPkg::*, aluBusPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    advance,
	input  logic    reqValid,
	input  aluReqS  req,
	output logic    decValid,
	output execS    exec
);

	logic [15:0] opc;
	logic        sizeBad;     // Long or size 11
	logic        regForm;     // Dn,Dn or -(An),-(An) form of X and BCD ops
	aluOpE       decOp;
	opSizeE      decSize;
	decodedOpS   decoded;

	assign opc     = req.opcode;
	assign sizeBad = opc[7];
	assign regForm = (opc[5:4] == 2'b00);
	assign decSize = opc[6] ? sizeWord : sizeByte;

	// Operation by opcode group
	always_comb begin
		decOp = opIllegal;
		case (opc[15:12])
			4'hd: decOp = (opc[8] && regForm) ? opAddx : opAdd;
			4'h9: decOp = (opc[8] && regForm) ? opSubx : opSub;
			4'hb: decOp = (opc[8] && opc[5:3] != 3'b001) ? opEor : opCmp;   // CMPM stays CMP
			4'hc: begin
				if (opc[8] && regForm)
					decOp = opc[6] ? opIllegal : opAbcd;   // EXG is not kept
				else
					decOp = opAnd;
			end
			4'h8: begin
				if (opc[8] && regForm)
					decOp = opc[6] ? opIllegal : opSbcd;
				else
					decOp = opOr;
			end
			4'h4: begin
				if (!opc[8]) begin
					case (opc[11:9])
						3'b000:  decOp = opNegx;
						3'b001:  decOp = opClr;
						3'b010:  decOp = opNeg;
						3'b011:  decOp = opNot;
						default: decOp = opIllegal;
					endcase
				end
			end
			4'he: begin
				// Register form, type in 4:3, direction in bit 8
				case ({opc[4:3], opc[8]})
					3'd0: decOp = opAsr;
					3'd1: decOp = opAsl;
					3'd2: decOp = opLsr;
					3'd3: decOp = opLsl;
					3'd4: decOp = opRoxr;
					3'd5: decOp = opRoxl;
					3'd6: decOp = opRor;
					3'd7: decOp = opRol;
				endcase
			end
			default: decOp = opIllegal;
		endcase
		if (sizeBad)
			decOp = opIllegal;   // Long, memory shifts, MUL/DIV, ADDA and friends
	end

	// Flags written per operation
	always_comb begin
		decoded.op      = decOp;
		decoded.size    = decSize;
		decoded.stickyZ = decOp inside {opAddx, opSubx, opNegx, opAbcd, opSbcd};
		case (decOp)
			opCmp, opAnd, opOr, opEor,
			opClr, opNot, opRol, opRor: decoded.ccrMask = maskNzvc;
			opIllegal:                  decoded.ccrMask = maskNone;
			default:                    decoded.ccrMask = maskAll;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			decValid <= 1'b0;
		else if (advance)
			decValid <= reqValid;
	end

	// Payload, no reset
	always_ff @(posedge clk) begin
		if (advance)
			exec <= '{dec: decoded, src: req.src, dst: req.dst};
	end

endmodule

`default_nettype wire

/* hw/aluExecute.sv */
// ALU execute stage: execute register, adder/subtractor, logic unit, one-place shifter
`timescale 1ns/100ps
`default_nettype none

module aluExecute
	import aluOpsPkg::*, aluBusPkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              advance,
	input  logic              decValid,
	input  execS              exec,
	input  logic [ccrW-1:0]   ccr,
	output logic              exValid,
	output decodedOpS         exOp,
	output logic [dataW-1:0]  rawResult,
	output logic              dstMsb,
	output logic              carryOut,
	output logic              overflow
);

	execS             exReg;
	aluOpE            op;
	logic             byteOp;
	logic             xIn;
	logic [dataW-1:0] src, dst;
	logic [dataW-1:0] opA, opB;          // opB - opA or opB + opA
	logic             isSub, cin;
	logic [dataW:0]   extA, extB, sum;   // One extra bit for carry
	logic             addCarry, addOv, halfCarry;
	logic             aMsb, bMsb, sumMsb;
	logic [7:0]       bcdResult;
	logic             decCarry, bcdOv;
	logic             shiftLeft, shiftIn, shiftOut;
	logic [dataW-1:0] shiftWord;
	logic [7:0]       shiftByte;
	logic [dataW-1:0] opResult;

	always_ff @(posedge clk) begin
		if (reset)
			exValid <= 1'b0;
		else if (advance)
			exValid <= decValid;
	end

	always_ff @(posedge clk) begin
		if (advance)
			exReg <= exec;
	end

	assign exOp   = exReg.dec;
	assign op     = exReg.dec.op;
	assign byteOp = (exReg.dec.size == sizeByte);
	assign src    = exReg.src;
	assign dst    = exReg.dst;
	assign xIn    = ccr[flagX];   // CCR already holds the previous op's flags
	assign dstMsb = byteOp ? dst[7] : dst[dataW-1];

	// Adder operand and carry-in selection
	always_comb begin
		isSub = 1'b1;
		opB   = dst;
		opA   = src;
		cin   = 1'b0;
		case (op)
			opAdd:          isSub = 1'b0;
			opAddx, opAbcd: begin isSub = 1'b0; cin = xIn; end
			opSubx, opSbcd: cin = xIn;
			opNeg:          begin opB = '0; opA = dst; end
			opNegx:         begin opB = '0; opA = dst; cin = xIn; end
			opNot:          begin opB = '0; opA = dst; cin = 1'b1; end   // 0 - d - 1
			default:        ;
		endcase
	end

	// Sized add/sub, carry lands in bit 8 or bit 16
	assign extA   = byteOp ? {{(dataW-7){1'b0}}, opA[7:0]} : {1'b0, opA};
	assign extB   = byteOp ? {{(dataW-7){1'b0}}, opB[7:0]} : {1'b0, opB};
	assign sum    = isSub ? extB - extA - {{dataW{1'b0}}, cin}
	                      : extB + extA + {{dataW{1'b0}}, cin};
	assign addCarry  = byteOp ? sum[8] : sum[dataW];
	assign sumMsb    = byteOp ? sum[7] : sum[dataW-1];
	assign aMsb      = byteOp ? opA[7] : opA[dataW-1];
	assign bMsb      = byteOp ? opB[7] : opB[dataW-1];
	assign halfCarry = extA[4] ^ extB[4] ^ sum[4];   // For decimal adjust
	assign addOv = isSub ? (~aMsb & bMsb & ~sumMsb) | (aMsb & ~bMsb & sumMsb)
	                     : (aMsb & bMsb & ~sumMsb) | (~aMsb & ~bMsb & sumMsb);

	bcdCorrect i_bcdCorrect (
		.binResult (sum[7:0]),
		.isAdd     (~isSub),
		.carryIn   (addCarry),
		.halfCarry (halfCarry),
		.bcdResult (bcdResult),
		.decCarry  (decCarry),
		.overflow  (bcdOv)
	);

	// One-place shifter
	assign shiftLeft = op inside {opAsl, opLsl, opRol, opRoxl};
	always_comb begin
		case (op)
			opAsr, opRol:   shiftIn = dstMsb;   // Sign fill or wrap
			opRor:          shiftIn = dst[0];
			opRoxl, opRoxr: shiftIn = xIn;
			default:        shiftIn = 1'b0;
		endcase
	end
	assign shiftWord = shiftLeft ? {dst[dataW-2:0], shiftIn} : {shiftIn, dst[dataW-1:1]};
	assign shiftByte = shiftLeft ? {dst[6:0], shiftIn} : {shiftIn, dst[7:1]};
	assign shiftOut  = shiftLeft ? dstMsb : dst[0];

	always_comb begin
		opResult = dst;   // Illegal passes dst through
		carryOut = 1'b0;
		overflow = 1'b0;
		case (op)
			opAdd, opAddx, opSub, opSubx,
			opCmp, opNeg, opNegx: begin
				opResult = sum[dataW-1:0];
				carryOut = addCarry;
				overflow = addOv;
			end
			opNot:          opResult = sum[dataW-1:0];
			opAnd:          opResult = src & dst;
			opOr:           opResult = src | dst;
			opEor:          opResult = src ^ dst;
			opClr:          opResult = '0;
			opAbcd, opSbcd: begin
				opResult = {dst[dataW-1:8], bcdResult};
				carryOut = decCarry;
				overflow = bcdOv;
			end
			opAsl, opAsr, opLsl, opLsr,
			opRol, opRor, opRoxl, opRoxr: begin
				opResult = byteOp ? {dst[dataW-1:8], shiftByte} : shiftWord;
				carryOut = shiftOut;
			end
			default:        ;
		endcase
	end

	// Byte ops keep dst's upper byte
	assign rawResult = byteOp ? {dst[dataW-1:8], opResult[7:0]} : opResult;

endmodule

`default_nettype wire

/* hw/ccrResult.sv */
// CCR stage: builds the flags, merges them through the mask, holds CCR and response
`timescale 1ns/100ps
`default_nettype none

module ccrResult
	import aluOpsPkg::*, aluBusPkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              advance,
	input  logic              exValid,
	input  decodedOpS         exOp,
	input  logic [dataW-1:0]  rawResult,
	input  logic              dstMsb,
	input  logic              carryOut,
	input  logic              overflow,
	output logic [ccrW-1:0]   ccr,
	output logic              respValid,
	output aluRespS           resp
);

	logic             byteOp;
	logic             resN, resZ;
	logic [ccrW-1:0]  flags;    // Candidate flags before mask
	logic [ccrW-1:0]  merged;   // Next CCR
	logic             illegal;

	assign byteOp  = (exOp.size == sizeByte);
	assign resN    = byteOp ? rawResult[7] : rawResult[dataW-1];
	assign resZ    = byteOp ? (rawResult[7:0] == 8'd0) : (rawResult == '0);
	assign illegal = (exOp.op == opIllegal);

	always_comb begin
		flags        = '0;
		flags[flagN] = resN;
		flags[flagZ] = resZ;
		flags[flagC] = carryOut;   // Carry, borrow, decimal carry or bit shifted out
		flags[flagX] = carryOut;
		flags[flagV] = overflow;
		case (exOp.op)
			opAsl: flags[flagV] = dstMsb ^ resN;   // Sign bit changed
			opAnd, opOr, opEor,
			opClr, opNot: begin
				flags[flagC] = 1'b0;
				flags[flagV] = 1'b0;
			end
			default: ;
		endcase

		merged = (flags & exOp.ccrMask) | (ccr & ~exOp.ccrMask);
		// X-forms and BCD only clear Z, so multi-precision chains work
		if (exOp.stickyZ)
			merged[flagZ] = resZ & ccr[flagZ];
	end

	// Control state and CCR
	always_ff @(posedge clk) begin
		if (reset) begin
			respValid <= 1'b0;
			ccr       <= '0;
		end else if (advance) begin
			respValid <= exValid;
			if (exValid)
				ccr <= merged;   // Same edge the op leaves execute
		end
	end

	// Response payload
	always_ff @(posedge clk) begin
		if (advance && exValid)
			resp <= '{result: rawResult, ccr: merged, illegal: illegal};
	end

endmodule

`default_nettype wire

/* hw/aluCore.sv */
// 68K-style ALU core top: decode, execute and CCR stages behind valid/ready handshakes
`timescale 1ns/100ps
`default_nettype none

module aluCore
	import aluOpsPkg::*, aluBusPkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     reqValid,
	output logic     reqReady,
	input  aluReqS   req,
	output logic     respValid,
	input  logic     respReady,
	output aluRespS  resp
);

	logic             advance;    // Whole pipe moves together
	logic             decValid;
	execS             exec;
	logic             exValid;
	decodedOpS        exOp;
	logic [dataW-1:0] rawResult;
	logic             dstMsb, carryOut, overflow;
	logic [ccrW-1:0]  ccr;

	// Stall only when a response is waiting and not taken
	assign advance  = ~respValid | respReady;
	assign reqReady = advance;

	opDecoder i_opDecoder (
		.clk      (clk),
		.reset    (reset),
		.advance  (advance),
		.reqValid (reqValid),
		.req      (req),
		.decValid (decValid),
		.exec     (exec)
	);

	aluExecute i_aluExecute (
		.clk       (clk),
		.reset     (reset),
		.advance   (advance),
		.decValid  (decValid),
		.exec      (exec),
		.ccr       (ccr),
		.exValid   (exValid),
		.exOp      (exOp),
		.rawResult (rawResult),
		.dstMsb    (dstMsb),
		.carryOut  (carryOut),
		.overflow  (overflow)
	);

	ccrResult i_ccrResult (
		.clk       (clk),
		.reset     (reset),
		.advance   (advance),
		.exValid   (exValid),
		.exOp      (exOp),
		.rawResult (rawResult),
		.dstMsb    (dstMsb),
		.carryOut  (carryOut),
		.overflow  (overflow),
		.ccr       (ccr),
		.respValid (respValid),
		.resp      (resp)
	);

endmodule

`default_nettype wire

/* tb/aluVectors.svh */
// ALU test vectors: requests with expected result, CCR and illegal bit, in issue order
`ifndef aluVectorsSvh
`define aluVectorsSvh

// Columns: opcode, src, dst, expected result, expected CCR (XNZVC), expected illegal
typedef struct packed {
	logic [15:0]      opcode;
	logic [dataW-1:0] src;
	logic [dataW-1:0] dst;
	logic [dataW-1:0] expResult;
	logic [ccrW-1:0]  expCcr;       // XNZVC
	logic             expIllegal;
} vectorS;

vectorS vecTable[$];

task automatic pushVector(input logic [15:0] opcode, input logic [dataW-1:0] src,
		input logic [dataW-1:0] dst, input logic [dataW-1:0] result,
		input logic [ccrW-1:0] ccr, input logic illegal);
	vectorS vec;
	vec.opcode     = opcode;
	vec.src        = src;
	vec.dst        = dst;
	vec.expResult  = result;
	vec.expCcr     = ccr;
	vec.expIllegal = illegal;
	vecTable.push_back(vec);
endtask

// Expected CCR of each row follows from the row above, CCR starts at 0
task automatic loadVectors();
	// Add, subtract, compare
	pushVector(16'hd001, 16'h00f0, 16'hab20, 16'hab10, 5'b10001, 1'b0);   // ADD.B carry
	pushVector(16'hd041, 16'h7000, 16'h1000, 16'h8000, 5'b01010, 1'b0);   // ADD.W overflow
	pushVector(16'hd001, 16'h0080, 16'h5580, 16'h5500, 5'b10111, 1'b0);   // ADD.B to zero
	pushVector(16'h9041, 16'h0001, 16'h0000, 16'hffff, 5'b11001, 1'b0);   // SUB.W borrow
	pushVector(16'hb001, 16'h0010, 16'haa10, 16'haa00, 5'b10100, 1'b0);   // CMP.B, X stays 1
	pushVector(16'h9001, 16'h0001, 16'h3480, 16'h347f, 5'b00010, 1'b0);   // SUB.B overflow
	pushVector(16'hb041, 16'h8000, 16'h0001, 16'h8001, 5'b01011, 1'b0);   // CMP.W, X stays 0
	// Logic and unary
	pushVector(16'hc041, 16'hf0f0, 16'h3c3c, 16'h3030, 5'b00000, 1'b0);   // AND.W
	pushVector(16'h8001, 16'h0080, 16'h1201, 16'h1281, 5'b01000, 1'b0);   // OR.B
	pushVector(16'hb141, 16'hffff, 16'hffff, 16'h0000, 5'b00100, 1'b0);   // EOR.W
	pushVector(16'h4600, 16'h0000, 16'h5a0f, 16'h5af0, 5'b01000, 1'b0);   // NOT.B
	pushVector(16'h4440, 16'h0000, 16'h0005, 16'hfffb, 5'b11001, 1'b0);   // NEG.W
	pushVector(16'h4240, 16'h0000, 16'h1234, 16'h0000, 5'b10100, 1'b0);   // CLR.W
	pushVector(16'h4400, 16'h0000, 16'h7780, 16'h7780, 5'b11011, 1'b0);   // NEG.B of 0x80
	pushVector(16'h4200, 16'h0000, 16'h12ff, 16'h1200, 5'b10100, 1'b0);   // CLR.B
	pushVector(16'h4640, 16'h0000, 16'h0000, 16'hffff, 5'b11000, 1'b0);   // NOT.W
	// X-forms chained back to back
	pushVector(16'hd041, 16'h8000, 16'h8000, 16'h0000, 5'b10111, 1'b0);   // Sets X and Z
	pushVector(16'hd141, 16'hffff, 16'h0000, 16'h0000, 5'b10101, 1'b0);   // ADDX.W, Z kept
	pushVector(16'hd141, 16'h0001, 16'h0002, 16'h0004, 5'b00000, 1'b0);   // ADDX.W, Z cleared
	pushVector(16'hd101, 16'h00ff, 16'h3301, 16'h3300, 5'b10001, 1'b0);   // Zero, Z not set
	pushVector(16'h9101, 16'h0000, 16'h4401, 16'h4400, 5'b00000, 1'b0);   // SUBX.B
	pushVector(16'h9141, 16'h0001, 16'h0000, 16'hffff, 5'b11001, 1'b0);   // SUBX.W borrow
	pushVector(16'h4040, 16'h0000, 16'h0000, 16'hffff, 5'b11001, 1'b0);   // NEGX.W
	pushVector(16'h4000, 16'h0000, 16'h5501, 16'h55fe, 5'b11001, 1'b0);   // NEGX.B
	pushVector(16'hd001, 16'h0000, 16'h0000, 16'h0000, 5'b00100, 1'b0);   // Z set, X clear
	pushVector(16'h4000, 16'h0000, 16'haa00, 16'haa00, 5'b00100, 1'b0);   // NEGX.B, Z kept
	// Decimal
	pushVector(16'hc101, 16'h0050, 16'h0050, 16'h0000, 5'b10101, 1'b0);   // 50+50, Z kept
	pushVector(16'hc101, 16'h0012, 16'h7734, 16'h7747, 5'b00000, 1'b0);   // 34+12+X
	pushVector(16'hc101, 16'h0045, 16'h1238, 16'h1283, 5'b01010, 1'b0);   // 38+45
	pushVector(16'hc101, 16'h0099, 16'h0001, 16'h0000, 5'b10001, 1'b0);   // 01+99 carry
	pushVector(16'hc101, 16'h0009, 16'hff09, 16'hff19, 5'b00000, 1'b0);   // Half carry
	pushVector(16'h8101, 16'h0025, 16'h0025, 16'h0000, 5'b00000, 1'b0);   // SBCD zero, Z not set
	pushVector(16'h8101, 16'h0001, 16'h3300, 16'h3399, 5'b11001, 1'b0);   // 00-01 borrow
	pushVector(16'h8101, 16'h0015, 16'h0042, 16'h0026, 5'b00000, 1'b0);   // 42-15-X
	// Shifts and rotates by one
	pushVector(16'he300, 16'h0000, 16'h1240, 16'h1280, 5'b01010, 1'b0);   // ASL.B sign change
	pushVector(16'he340, 16'h0000, 16'h8001, 16'h0002, 5'b10011, 1'b0);   // ASL.W
	pushVector(16'he200, 16'h0000, 16'h0081, 16'h00c0, 5'b11001, 1'b0);   // ASR.B sign fill
	pushVector(16'he240, 16'h0000, 16'h4002, 16'h2001, 5'b00000, 1'b0);   // ASR.W
	pushVector(16'he308, 16'h0000, 16'hff80, 16'hff00, 5'b10101, 1'b0);   // LSL.B
	pushVector(16'he348, 16'h0000, 16'h4000, 16'h8000, 5'b01000, 1'b0);   // LSL.W, no V
	pushVector(16'he208, 16'h0000, 16'h3301, 16'h3300, 5'b10101, 1'b0);   // LSR.B
	pushVector(16'he248, 16'h0000, 16'h8000, 16'h4000, 5'b00000, 1'b0);   // LSR.W
	pushVector(16'he310, 16'h0000, 16'h0080, 16'h0000, 5'b10101, 1'b0);   // ROXL.B, X=0 in
	pushVector(16'he350, 16'h0000, 16'h4000, 16'h8001, 5'b01000, 1'b0);   // ROXL.W, X=1 in
	pushVector(16'he250, 16'h0000, 16'h0001, 16'h0000, 5'b10101, 1'b0);   // ROXR.W
	pushVector(16'he210, 16'h0000, 16'h7702, 16'h7781, 5'b01000, 1'b0);   // ROXR.B, X=1 in
	pushVector(16'he308, 16'h0000, 16'h0080, 16'h0000, 5'b10101, 1'b0);   // Sets X for rotates
	pushVector(16'he318, 16'h0000, 16'h1201, 16'h1202, 5'b10000, 1'b0);   // ROL.B, X kept
	pushVector(16'he358, 16'h0000, 16'h8000, 16'h0001, 5'b10001, 1'b0);   // ROL.W wrap
	pushVector(16'he218, 16'h0000, 16'h0001, 16'h0080, 5'b11001, 1'b0);   // ROR.B wrap
	pushVector(16'he258, 16'h0000, 16'h0002, 16'h0001, 5'b10000, 1'b0);   // ROR.W
	// Illegal, CCR must survive
	pushVector(16'hd081, 16'h1111, 16'h2222, 16'h2222, 5'b10000, 1'b1);   // ADD.L
	pushVector(16'h4e71, 16'h0000, 16'hbeef, 16'hbeef, 5'b10000, 1'b1);   // NOP
	pushVector(16'hc141, 16'h0000, 16'h5555, 16'h5555, 5'b10000, 1'b1);   // EXG
	pushVector(16'hd041, 16'h0000, 16'h0000, 16'h0000, 5'b00100, 1'b0);   // Legal again
endtask

`endif

/* tb/aluCoreTb.sv */
// ALU core testbench: table-driven requests, random response back-pressure, in-order checks
`timescale 1ns/100ps
`default_nettype none

module aluCoreTb
	import aluOpsPkg::*, aluBusPkg::*;
();

	logic     clk;
	logic     reset;
	logic     reqValid;
	logic     reqReady;
	aluReqS   req;
	logic     respValid;
	logic     respReady;
	aluRespS  resp;

	int       checkCount    = 0;
	int       mismatchCount = 0;
	int       otherErrors   = 0;   // Timeout, lost or extra responses
	int       rcvCount      = 0;   // Responses taken so far
	int       cycleCount    = 0;
	int       cycleLimit;
	logic     holding       = 1'b0;   // Response stalled at the last check
	aluRespS  heldResp;

	`include "aluVectors.svh"

	aluCore i_aluCore (
		.clk       (clk),
		.reset     (reset),
		.reqValid  (reqValid),
		.reqReady  (reqReady),
		.req       (req),
		.respValid (respValid),
		.respReady (respReady),
		.resp      (resp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;   // 40 ns period
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			mismatchCount++;
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, actual,
				expected);
		end
	endtask

	// Compares the response now on the port with table row idx
	task automatic checkResponse(input int idx);
		if (idx >= vecTable.size()) begin
			otherErrors++;
			$display("Extra response at %0t ns after all %0d requests were answered", $time,
				vecTable.size());
		end else begin
			checkValue($sformatf("result[%0d]", idx), 32'(resp.result),
				32'(vecTable[idx].expResult));
			checkValue($sformatf("ccr[%0d]", idx), 32'(resp.ccr), 32'(vecTable[idx].expCcr));
			checkValue($sformatf("illegal[%0d]", idx), 32'(resp.illegal),
				32'(vecTable[idx].expIllegal));
		end
	endtask

	task automatic reportAndStop();
		$display("Checks %0d, mismatches %0d, other errors %0d", checkCount, mismatchCount,
			otherErrors);
		if (mismatchCount == 0 && otherErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	// Requests, one table row per transfer
	initial begin
		int sendIdx;
		reset     = 1'b1;
		reqValid  = 1'b0;
		req       = '0;
		loadVectors();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (sendIdx = 0; sendIdx < vecTable.size(); sendIdx++) begin
			reqValid <= 1'b1;
			req      <= '{opcode: vecTable[sendIdx].opcode, src: vecTable[sendIdx].src,
				dst: vecTable[sendIdx].dst};
			@(negedge clk);
			while (!reqReady)   // Stalled by back-pressure
				@(negedge clk);
			@(posedge clk);     // Transfer edge
		end
		reqValid <= 1'b0;
		while (rcvCount < vecTable.size())
			@(posedge clk);
		repeat (5) @(posedge clk);   // Room for a stray extra response
		reportAndStop();
	end

	// Random back-pressure, ready about three cycles in four
	initial begin
		respReady = 1'b0;
		void'($urandom(32'hd31a_6363));   // Seed once for the whole run
		forever begin
			@(posedge clk);
			respReady <= ($urandom % 4) != 0;
		end
	end

	// Responses sampled mid-cycle, transfer happens on the next rising edge
	always @(negedge clk) begin
		if (!reset) begin
			if (holding) begin
				if (!respValid) begin
					otherErrors++;
					$display("Response %0d was withdrawn before it was accepted, at %0t ns",
						rcvCount, $time);
				end else
					checkValue("resp while stalled", 32'(resp), 32'(heldResp));
			end
			if (respValid && respReady) begin
				checkResponse(rcvCount);
				rcvCount++;
			end
			holding  = respValid && !respReady;
			heldResp = resp;
		end
	end

	// Watchdog sized from the table length
	initial begin
		@(posedge clk);
		cycleLimit = 10 * vecTable.size() + 100;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		otherErrors++;
		$display("Timeout after %0d cycles with %0d of %0d responses received", cycleCount,
			rcvCount, vecTable.size());
		reportAndStop();
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+tb
hw/aluOpsPkg.sv
hw/aluBusPkg.sv
hw/bcdCorrect.sv
hw/opDecoder.sv
hw/aluExecute.sv
hw/ccrResult.sv
hw/aluCore.sv
tb/aluCoreTb.sv

/* run.sh */
#!/bin/sh
# Builds the ALU core testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module aluCoreTb \
	-o aluCoreSim
./obj_dir/aluCoreSim > sim.log
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0
